//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := mem_subsys_tb
FILELIST  := mem_subsys_top.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# Pass only if the simulation prints the pass line
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /^Test passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

//--- hw/bank_if.sv
interface bank_if;

	logic                req_valid;
	logic                req_ready;
	mem_pkg::bank_req_t  req;

	logic                rsp_valid;
	logic                rsp_ready;
	mem_pkg::bank_rsp_t  rsp;

	modport xbar (
		output req_valid,
		output req,
		input  req_ready
	);

	modport bank (
		input  req_valid,
		input  req,
		output req_ready,
		output rsp_valid,
		output rsp,
		input  rsp_ready
	);

	modport collect (
		input  rsp_valid,
		input  rsp,
		output rsp_ready
	);

endinterface

//--- hw/bus_fifo.sv
module bus_fifo #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     in_ready,
	output logic     out_valid,
	output payload_t out_data,
	input  logic     out_ready
);

	payload_t   slot_q [2];
	logic       wr_ptr;
	logic       rd_ptr;
	logic [1:0] count;
	logic       push;
	logic       pop;

	assign in_ready  = (count != 2'd2);
	assign out_valid = (count != 2'd0);
	assign out_data  = slot_q[rd_ptr];

	assign push = in_valid & in_ready;
	assign pop  = out_valid & out_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end else begin
			if (push) wr_ptr <= ~wr_ptr;
			if (pop) rd_ptr <= ~rd_ptr;
			count <= count + {1'b0, push} - {1'b0, pop};
		end
	end

	always_ff @(posedge clk) begin
		if (push) slot_q[wr_ptr] <= in_data;
	end

endmodule

//--- hw/bus_pkg.sv
package bus_pkg;

	// Number of requesting channels, one tag each
	localparam int NUM_CH = 3;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_e;

	// Tag value doubles as the channel index in retire and busy vectors
	typedef enum logic [1:0] {
		TAG_IFU    = 2'd0,
		TAG_LSU_RD = 2'd1,
		TAG_LSU_WR = 2'd2
	} tag_e;

endpackage

//--- hw/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

//////////////////////////////////////////////////
// Bus widths
`define ADDR_W 32
`define DATA_W 32
`define STRB_W (`DATA_W / 8)

//////////////////////////////////////////////////
// Word-interleaved banks on addr[3:2]
`define NUM_BANKS 4
`define BANK_SEL_W 2
`define BANK_WORDS 256
`define BANK_IDX_W (`ADDR_W - 4) // Full width so a bank can flag out of range

//////////////////////////////////////////////////
// Per-bank delay generator
`define LFSR_W 8
`define LFSR_SEED 8'h5a
`define LFSR_TAPS 8'hb8 // Maximal-length Galois taps

`endif

//--- hw/mem_pkg.sv
`include "mem_consts.svh"

package mem_pkg;

	import bus_pkg::*;

	// Request as seen by one bank
	typedef struct packed {
		tag_e                   tag;
		logic                   we;
		logic [`BANK_IDX_W-1:0] idx;
		logic [`DATA_W-1:0]     wdata;
		logic [`STRB_W-1:0]     wstrb;
	} bank_req_t;

	typedef struct packed {
		tag_e               tag;
		logic [`DATA_W-1:0] rdata;
		resp_e              resp;
	} bank_rsp_t;

	// Payload of a read channel FIFO
	typedef struct packed {
		logic [`DATA_W-1:0] data;
		resp_e              resp;
	} rd_beat_t;

endpackage

//--- hw/mem_resp_collect.sv
`include "mem_consts.svh"

module mem_resp_collect import bus_pkg::*; import mem_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	bank_if.collect            banks [`NUM_BANKS],

	output logic [`DATA_W-1:0] ifu_rdata,
	output resp_e              ifu_rresp,
	output logic               ifu_rvalid,
	input  logic               ifu_rready,

	output logic [`DATA_W-1:0] lsu_rdata,
	output resp_e              lsu_rresp,
	output logic               lsu_rvalid,
	input  logic               lsu_rready,

	output resp_e              lsu_bresp,
	output logic               lsu_bvalid,
	input  logic               lsu_bready,

	output logic [NUM_CH-1:0]  retire
);

	bank_rsp_t             rsp     [`NUM_BANKS];
	logic [`NUM_BANKS-1:0] rsp_vld;
	bank_rsp_t             ch_rsp  [NUM_CH];
	logic [NUM_CH-1:0]     ch_vld;
	logic [NUM_CH-1:0]     ch_rdy;
	rd_beat_t              ifu_in, ifu_out;
	rd_beat_t              lsu_in, lsu_out;

	generate
		for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank
			assign rsp_vld[b]        = banks[b].rsp_valid;
			assign rsp[b]            = banks[b].rsp;
			assign banks[b].rsp_ready = ch_rdy[banks[b].rsp.tag];
		end
	endgenerate

	// A tag lives in at most one bank, so plain OR routing is enough
	always_comb begin
		for (int c = 0; c < NUM_CH; c++) begin
			ch_vld[c] = 1'b0;
			ch_rsp[c] = '0;
			for (int b = 0; b < `NUM_BANKS; b++) begin
				if (rsp_vld[b] && rsp[b].tag == tag_e'(c)) begin
					ch_vld[c] = 1'b1;
					ch_rsp[c] = rsp[b];
				end
			end
		end
	end

	assign ifu_in = '{data: ch_rsp[TAG_IFU].rdata, resp: ch_rsp[TAG_IFU].resp};
	assign lsu_in = '{data: ch_rsp[TAG_LSU_RD].rdata, resp: ch_rsp[TAG_LSU_RD].resp};

	bus_fifo #(.payload_t(rd_beat_t)) u_ifu_fifo (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (ch_vld[TAG_IFU]),
		.in_data   (ifu_in),
		.in_ready  (ch_rdy[TAG_IFU]),
		.out_valid (ifu_rvalid),
		.out_data  (ifu_out),
		.out_ready (ifu_rready)
	);

	bus_fifo #(.payload_t(rd_beat_t)) u_lsu_rd_fifo (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (ch_vld[TAG_LSU_RD]),
		.in_data   (lsu_in),
		.in_ready  (ch_rdy[TAG_LSU_RD]),
		.out_valid (lsu_rvalid),
		.out_data  (lsu_out),
		.out_ready (lsu_rready)
	);

	bus_fifo #(.payload_t(resp_e)) u_lsu_wr_fifo (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (ch_vld[TAG_LSU_WR]),
		.in_data   (ch_rsp[TAG_LSU_WR].resp),
		.in_ready  (ch_rdy[TAG_LSU_WR]),
		.out_valid (lsu_bvalid),
		.out_data  (lsu_bresp),
		.out_ready (lsu_bready)
	);

	assign ifu_rdata = ifu_out.data;
	assign ifu_rresp = ifu_out.resp;
	assign lsu_rdata = lsu_out.data;
	assign lsu_rresp = lsu_out.resp;

	// Frees the channel in the crossbar
	assign retire = {lsu_bvalid & lsu_bready, lsu_rvalid & lsu_rready, ifu_rvalid & ifu_rready};

endmodule

//--- hw/mem_subsys_top.sv
`include "mem_consts.svh"

module mem_subsys_top (
	input  logic               clk,
	input  logic               arst_n,

	input  logic [`ADDR_W-1:0] ifu_araddr,
	input  logic               ifu_arvalid,
	output logic               ifu_arready,
	output logic [`DATA_W-1:0] ifu_rdata,
	output logic [1:0]         ifu_rresp,
	output logic               ifu_rvalid,
	input  logic               ifu_rready,

	input  logic [`ADDR_W-1:0] lsu_araddr,
	input  logic               lsu_arvalid,
	output logic               lsu_arready,
	output logic [`DATA_W-1:0] lsu_rdata,
	output logic [1:0]         lsu_rresp,
	output logic               lsu_rvalid,
	input  logic               lsu_rready,

	input  logic [`ADDR_W-1:0] lsu_awaddr,
	input  logic               lsu_awvalid,
	output logic               lsu_awready,
	input  logic [`DATA_W-1:0] lsu_wdata,
	input  logic [`STRB_W-1:0] lsu_wstrb,
	input  logic               lsu_wvalid,
	output logic               lsu_wready,
	output logic [1:0]         lsu_bresp,
	output logic               lsu_bvalid,
	input  logic               lsu_bready
);

	logic [2:0] retire; // one bit per tag

	bank_if bank_bus [`NUM_BANKS] ();

	mem_xbar u_xbar (
		.clk         (clk),
		.arst_n      (arst_n),
		.ifu_araddr  (ifu_araddr),
		.ifu_arvalid (ifu_arvalid),
		.ifu_arready (ifu_arready),
		.lsu_araddr  (lsu_araddr),
		.lsu_arvalid (lsu_arvalid),
		.lsu_arready (lsu_arready),
		.lsu_awaddr  (lsu_awaddr),
		.lsu_awvalid (lsu_awvalid),
		.lsu_awready (lsu_awready),
		.lsu_wdata   (lsu_wdata),
		.lsu_wstrb   (lsu_wstrb),
		.lsu_wvalid  (lsu_wvalid),
		.lsu_wready  (lsu_wready),
		.retire      (retire),
		.banks       (bank_bus)
	);

	generate
		for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank
			sram_bank u_bank (
				.clk    (clk),
				.arst_n (arst_n),
				.port   (bank_bus[b])
			);
		end
	endgenerate

	mem_resp_collect u_collect (
		.clk        (clk),
		.arst_n     (arst_n),
		.banks      (bank_bus),
		.ifu_rdata  (ifu_rdata),
		.ifu_rresp  (ifu_rresp),
		.ifu_rvalid (ifu_rvalid),
		.ifu_rready (ifu_rready),
		.lsu_rdata  (lsu_rdata),
		.lsu_rresp  (lsu_rresp),
		.lsu_rvalid (lsu_rvalid),
		.lsu_rready (lsu_rready),
		.lsu_bresp  (lsu_bresp),
		.lsu_bvalid (lsu_bvalid),
		.lsu_bready (lsu_bready),
		.retire     (retire)
	);

endmodule

//--- hw/mem_xbar.sv
`include "mem_consts.svh"

module mem_xbar import bus_pkg::*; import mem_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,

	input  logic [`ADDR_W-1:0]   ifu_araddr,
	input  logic                 ifu_arvalid,
	output logic                 ifu_arready,

	input  logic [`ADDR_W-1:0]   lsu_araddr,
	input  logic                 lsu_arvalid,
	output logic                 lsu_arready,

	input  logic [`ADDR_W-1:0]   lsu_awaddr,
	input  logic                 lsu_awvalid,
	output logic                 lsu_awready,
	input  logic [`DATA_W-1:0]   lsu_wdata,
	input  logic [`STRB_W-1:0]   lsu_wstrb,
	input  logic                 lsu_wvalid,
	output logic                 lsu_wready,

	input  logic [NUM_CH-1:0]    retire,
	bank_if.xbar                 banks [`NUM_BANKS]
);

	logic [NUM_CH-1:0]      ch_valid;
	logic [NUM_CH-1:0]      ch_ready;
	logic [NUM_CH-1:0]      busy;
	logic [`ADDR_W-1:0]     ch_addr [NUM_CH];
	logic [`BANK_SEL_W-1:0] ch_sel  [NUM_CH];
	bank_req_t              ch_req  [NUM_CH];
	logic [NUM_CH-1:0]      bank_gnt [`NUM_BANKS];
	logic [1:0]             rr_ptr   [`NUM_BANKS];
	logic [`NUM_BANKS-1:0]  bank_rdy;

	// First requester at or after the pointer
	function automatic logic [NUM_CH-1:0] rr_pick(input logic [NUM_CH-1:0] req,
			input logic [1:0] ptr);
		logic [NUM_CH-1:0] gnt;
		logic              found;
		int                idx;
		gnt   = '0;
		found = 1'b0;
		for (int i = 0; i < NUM_CH; i++) begin
			idx = (int'(ptr) + i) % NUM_CH;
			if (!found && req[idx]) begin
				gnt[idx] = 1'b1;
				found    = 1'b1;
			end
		end
		return gnt;
	endfunction

	assign ch_valid = {lsu_awvalid & lsu_wvalid, lsu_arvalid, ifu_arvalid};
	assign ch_addr[TAG_IFU]    = ifu_araddr;
	assign ch_addr[TAG_LSU_RD] = lsu_araddr;
	assign ch_addr[TAG_LSU_WR] = lsu_awaddr;

	always_comb begin
		for (int c = 0; c < NUM_CH; c++) begin
			ch_sel[c]       = ch_addr[c][3:2];
			ch_req[c].tag   = tag_e'(c);
			ch_req[c].we    = (c == int'(TAG_LSU_WR));
			ch_req[c].idx   = ch_addr[c][`ADDR_W-1:4];
			ch_req[c].wdata = lsu_wdata;
			ch_req[c].wstrb = (c == int'(TAG_LSU_WR)) ? lsu_wstrb : '0;
		end
	end

	//////////////////////////////////////////////////
	// Per-bank arbitration
	generate
		for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_arb
			logic [NUM_CH-1:0] req_vec;

			always_comb begin
				for (int c = 0; c < NUM_CH; c++)
					req_vec[c] = ch_valid[c] & ~busy[c] & (ch_sel[c] == `BANK_SEL_W'(b));
			end

			assign bank_gnt[b]       = rr_pick(req_vec, rr_ptr[b]);
			assign bank_rdy[b]       = banks[b].req_ready;
			assign banks[b].req_valid = |bank_gnt[b];
			assign banks[b].req = bank_gnt[b][TAG_LSU_WR] ? ch_req[TAG_LSU_WR] :
				bank_gnt[b][TAG_LSU_RD] ? ch_req[TAG_LSU_RD] : ch_req[TAG_IFU];

			always_ff @(posedge clk or negedge arst_n) begin
				if (!arst_n) begin
					rr_ptr[b] <= 2'd0;
				end else if (|bank_gnt[b] && bank_rdy[b]) begin
					for (int c = 0; c < NUM_CH; c++)
						if (bank_gnt[b][c]) rr_ptr[b] <= 2'((c + 1) % NUM_CH); // winner goes last
				end
			end
		end
	endgenerate

	always_comb begin
		for (int c = 0; c < NUM_CH; c++)
			ch_ready[c] = bank_gnt[ch_sel[c]][c] & bank_rdy[ch_sel[c]];
	end

	assign ifu_arready = ch_ready[TAG_IFU];
	assign lsu_arready = ch_ready[TAG_LSU_RD];
	assign lsu_awready = ch_ready[TAG_LSU_WR];
	assign lsu_wready  = ch_ready[TAG_LSU_WR];

	// One outstanding request per channel
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) busy <= '0;
		else busy <= (busy & ~retire) | (ch_valid & ch_ready);
	end

endmodule

//--- hw/sram_bank.sv
`include "mem_consts.svh"

module sram_bank import bus_pkg::*; import mem_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	bank_if.bank port
);

	localparam int MEM_AW = $clog2(`BANK_WORDS);

	logic [`DATA_W-1:0] mem [`BANK_WORDS];
	logic [`LFSR_W-1:0] lfsr;
	logic [`LFSR_W-1:0] lfsr_next;
	logic [1:0]         delay_cnt;
	logic               pend;
	logic               accept;
	logic               in_range;
	logic [MEM_AW-1:0]  widx;
	bank_rsp_t          rsp_q;

	assign accept   = port.req_valid & port.req_ready;
	assign in_range = (port.req.idx < `BANK_IDX_W'(`BANK_WORDS));
	assign widx     = port.req.idx[MEM_AW-1:0];

	assign lfsr_next = {1'b0, lfsr[`LFSR_W-1:1]} ^ (lfsr[0] ? `LFSR_TAPS : '0);

	assign port.req_ready = ~pend; // idle only
	assign port.rsp_valid = pend & (delay_cnt == 2'd0);
	assign port.rsp       = rsp_q;

	//////////////////////////////////////////////////
	// Control and delay
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pend      <= 1'b0;
			delay_cnt <= 2'd0;
			lfsr      <= `LFSR_SEED;
		end else begin
			if (accept) begin
				pend      <= 1'b1;
				delay_cnt <= lfsr[1:0]; // 0 to 3 extra cycles
				lfsr      <= lfsr_next;
			end else if (port.rsp_valid && port.rsp_ready) begin
				pend <= 1'b0;
			end else if (pend && delay_cnt != 2'd0) begin
				delay_cnt <= delay_cnt - 2'd1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Array access at accept while the answer waits in rsp_q
	always_ff @(posedge clk) begin
		if (accept) begin
			rsp_q.tag <= port.req.tag;
			if (!in_range) begin
				rsp_q.resp  <= SLVERR;
				rsp_q.rdata <= '0;
			end else if (port.req.we) begin
				rsp_q.resp  <= OKAY;
				rsp_q.rdata <= '0;
				for (int i = 0; i < `STRB_W; i++) begin
					if (port.req.wstrb[i])
						mem[widx][8*i +: 8] <= port.req.wdata[8*i +: 8];
				end
			end else begin
				rsp_q.resp  <= OKAY;
				rsp_q.rdata <= mem[widx];
			end
		end
	end

endmodule

//--- mem_subsys_top.f
+incdir+hw
hw/bus_pkg.sv
hw/mem_pkg.sv
hw/bank_if.sv
hw/bus_fifo.sv
hw/mem_xbar.sv
hw/sram_bank.sv
hw/mem_resp_collect.sv
hw/mem_subsys_top.sv
verif/mem_subsys_props.sv
verif/mem_subsys_tb.sv

//--- verif/mem_subsys_props.sv
`include "mem_consts.svh"

module mem_subsys_props (
	input logic               clk,
	input logic               arst_n,
	input logic               ifu_arvalid,
	input logic               ifu_arready,
	input logic [`DATA_W-1:0] ifu_rdata,
	input logic               ifu_rvalid,
	input logic               ifu_rready,
	input logic               lsu_arvalid,
	input logic               lsu_arready,
	input logic [`DATA_W-1:0] lsu_rdata,
	input logic               lsu_rvalid,
	input logic               lsu_rready,
	input logic               lsu_awvalid,
	input logic               lsu_awready,
	input logic               lsu_bvalid,
	input logic               lsu_bready
);

	int unsigned viol_count = 0; // Failed assertions so far
	logic        ifu_open;
	logic        lsu_rd_open;
	logic        lsu_wr_open;

	// Open request per channel from address handshake to response
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ifu_open    <= 1'b0;
			lsu_rd_open <= 1'b0;
			lsu_wr_open <= 1'b0;
		end else begin
			ifu_open    <= (ifu_open & ~(ifu_rvalid & ifu_rready)) | (ifu_arvalid & ifu_arready);
			lsu_rd_open <= (lsu_rd_open & ~(lsu_rvalid & lsu_rready)) | (lsu_arvalid & lsu_arready);
			lsu_wr_open <= (lsu_wr_open & ~(lsu_bvalid & lsu_bready)) | (lsu_awvalid & lsu_awready);
		end
	end

	//////////////////////////////////////////////////
	// Response hold under back-pressure
	a_ifu_r_hold: assert property (@(posedge clk) disable iff (!arst_n)
		ifu_rvalid && !ifu_rready |=> ifu_rvalid && $stable(ifu_rdata))
		else begin
			viol_count++;
			$error("ifu r channel dropped or changed before rready");
		end

	a_lsu_r_hold: assert property (@(posedge clk) disable iff (!arst_n)
		lsu_rvalid && !lsu_rready |=> lsu_rvalid && $stable(lsu_rdata))
		else begin
			viol_count++;
			$error("lsu r channel dropped or changed before rready");
		end

	a_lsu_b_hold: assert property (@(posedge clk) disable iff (!arst_n)
		lsu_bvalid && !lsu_bready |=> lsu_bvalid)
		else begin
			viol_count++;
			$error("lsu bvalid dropped before bready");
		end

	//////////////////////////////////////////////////
	// No response without a request
	a_ifu_orphan: assert property (@(posedge clk) disable iff (!arst_n) ifu_rvalid |-> ifu_open)
		else begin
			viol_count++;
			$error("ifu rvalid with no outstanding read");
		end

	a_lsu_rd_orphan: assert property (@(posedge clk) disable iff (!arst_n)
		lsu_rvalid |-> lsu_rd_open)
		else begin
			viol_count++;
			$error("lsu rvalid with no outstanding read");
		end

	a_lsu_wr_orphan: assert property (@(posedge clk) disable iff (!arst_n)
		lsu_bvalid |-> lsu_wr_open)
		else begin
			viol_count++;
			$error("lsu bvalid with no outstanding write");
		end

endmodule

bind mem_subsys_top mem_subsys_props u_props (.*);

//--- verif/mem_subsys_tb.sv
`include "mem_consts.svh"

module mem_subsys_tb import bus_pkg::*; ();

	localparam int NUM_XFERS  = 63; // sum over all tests below
	localparam int MAX_CYCLES = 8 * NUM_XFERS + 200;

	logic               clk = 1'b0;
	logic               arst_n;
	logic [`ADDR_W-1:0] ifu_araddr, lsu_araddr, lsu_awaddr;
	logic               ifu_arvalid, lsu_arvalid, lsu_awvalid, lsu_wvalid;
	logic               ifu_arready, lsu_arready, lsu_awready, lsu_wready;
	logic [`DATA_W-1:0] ifu_rdata, lsu_rdata, lsu_wdata;
	logic [`STRB_W-1:0] lsu_wstrb;
	logic [1:0]         ifu_rresp, lsu_rresp, lsu_bresp;
	logic               ifu_rvalid, lsu_rvalid, lsu_bvalid;
	logic               ifu_rready, lsu_rready, lsu_bready;

	int                 seed = 32'h6e018a0c;
	int                 cycles = 0;
	int                 errors = 0;
	int                 err_start;
	int                 tests_ok = 0;
	int                 tests_bad = 0;
	string              cur_test = "startup";
	logic [`DATA_W-1:0] model [1024]; // word image of addresses below 0x1000
	logic [`ADDR_W-1:0] wr_addr [16];

	mem_subsys_top dut_i (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles in %s, a handshake or response never came",
				cycles, cur_test);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Bookkeeping and reference model
	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("** Error: %s, %s: expected %08h, actual %08h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test  = name;
		err_start = errors;
		@(posedge clk);
		#1;
	endtask

	task automatic end_test();
		if (errors == err_start) begin
			tests_ok++;
			$display("%-18s ok", cur_test);
		end else begin
			tests_bad++;
			$display("%-18s %0d mismatches", cur_test, errors - err_start);
		end
	endtask

	function automatic void apply_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		for (int i = 0; i < 4; i++)
			if (strb[i]) model[addr[11:2]][8*i +: 8] = data[8*i +: 8];
	endfunction

	//////////////////////////////////////////////////
	// Channel drivers where hold delays the ready after valid
	task automatic ifu_read(input logic [31:0] addr, input int hold,
			output logic [31:0] data, output logic [1:0] resp);
		ifu_araddr  = addr;
		ifu_arvalid = 1'b1;
		do @(negedge clk); while (!ifu_arready);
		@(posedge clk);
		#1 ifu_arvalid = 1'b0;
		do @(negedge clk); while (!ifu_rvalid);
		repeat (hold) @(negedge clk);
		@(posedge clk);
		#1 ifu_rready = 1'b1;
		@(negedge clk);
		data = ifu_rdata;
		resp = ifu_rresp;
		@(posedge clk);
		#1 ifu_rready = 1'b0;
	endtask

	task automatic lsu_read(input logic [31:0] addr, input int hold,
			output logic [31:0] data, output logic [1:0] resp);
		lsu_araddr  = addr;
		lsu_arvalid = 1'b1;
		do @(negedge clk); while (!lsu_arready);
		@(posedge clk);
		#1 lsu_arvalid = 1'b0;
		do @(negedge clk); while (!lsu_rvalid);
		repeat (hold) @(negedge clk);
		@(posedge clk);
		#1 lsu_rready = 1'b1;
		@(negedge clk);
		data = lsu_rdata;
		resp = lsu_rresp;
		@(posedge clk);
		#1 lsu_rready = 1'b0;
	endtask

	task automatic lsu_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input int hold, output logic [1:0] resp);
		lsu_awaddr  = addr;
		lsu_wdata   = data;
		lsu_wstrb   = strb;
		lsu_awvalid = 1'b1;
		lsu_wvalid  = 1'b1;
		do @(negedge clk); while (!(lsu_awready && lsu_wready));
		@(posedge clk);
		#1;
		lsu_awvalid = 1'b0;
		lsu_wvalid  = 1'b0;
		do @(negedge clk); while (!lsu_bvalid);
		repeat (hold) @(negedge clk);
		@(posedge clk);
		#1 lsu_bready = 1'b1;
		@(negedge clk);
		resp = lsu_bresp;
		@(posedge clk);
		#1 lsu_bready = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	task automatic reset_state();
		logic [31:0] d;
		logic [1:0]  r;
		begin_test("reset_state");
		check_val("ifu_rvalid", 32'd0, {31'd0, ifu_rvalid});
		check_val("lsu_rvalid", 32'd0, {31'd0, lsu_rvalid});
		check_val("lsu_bvalid", 32'd0, {31'd0, lsu_bvalid});
		ifu_read(32'h0, 0, d, r); // Unwritten memory so only the code matters
		check_val("first read resp", 32'(OKAY), {30'd0, r});
		end_test();
	endtask

	task automatic write_read_back();
		logic [31:0] d;
		logic [1:0]  r;
		begin_test("write_read_back");
		for (int i = 0; i < 16; i++) begin
			wr_addr[i] = {21'd0, 7'($random(seed)), 2'(i), 2'b00}; // cycles through banks
			d = $random(seed);
			lsu_write(wr_addr[i], d, 4'hf, 0, r);
			check_val("write resp", 32'(OKAY), {30'd0, r});
			apply_write(wr_addr[i], d, 4'hf);
		end
		for (int i = 0; i < 16; i++) begin
			lsu_read(wr_addr[i], 0, d, r);
			check_val("read data", model[wr_addr[i][11:2]], d);
			check_val("read resp", 32'(OKAY), {30'd0, r});
		end
		end_test();
	endtask

	task automatic byte_strobes();
		logic [31:0] d;
		logic [1:0]  r;
		begin_test("byte_strobes");
		lsu_write(32'h0a4, 32'h11223344, 4'hf, 0, r);
		apply_write(32'h0a4, 32'h11223344, 4'hf);
		d = $random(seed);
		lsu_write(32'h0a4, d, 4'b0101, 0, r);
		apply_write(32'h0a4, d, 4'b0101);
		ifu_read(32'h0a4, 0, d, r);
		check_val("merged word", model[32'h0a4 >> 2], d);
		check_val("read resp", 32'(OKAY), {30'd0, r});
		end_test();
	endtask

	task automatic concurrent_reads();
		logic [31:0] d, di, dl;
		logic [1:0]  r, ri, rl;
		begin_test("concurrent_reads");
		for (int k = 0; k < 3; k++) begin
			d = $random(seed);
			lsu_write(32'h200 + 32'(k * 4) + (k == 2 ? 32'h8 : 32'h0), d, 4'hf, 0, r);
			apply_write(32'h200 + 32'(k * 4) + (k == 2 ? 32'h8 : 32'h0), d, 4'hf);
		end
		fork // banks 0 and 1
			ifu_read(32'h200, 0, di, ri);
			lsu_read(32'h204, 0, dl, rl);
		join
		check_val("ifu data, split banks", model[32'h200 >> 2], di);
		check_val("lsu data, split banks", model[32'h204 >> 2], dl);
		fork // both on bank 0
			ifu_read(32'h210, 0, di, ri);
			lsu_read(32'h200, 0, dl, rl);
		join
		check_val("ifu data, same bank", model[32'h210 >> 2], di);
		check_val("lsu data, same bank", model[32'h200 >> 2], dl);
		check_val("resp codes", 32'(OKAY), {30'd0, ri | rl});
		end_test();
	endtask

	task automatic out_of_range();
		logic [31:0] d;
		logic [1:0]  r;
		begin_test("out_of_range");
		d = $random(seed);
		lsu_write(32'h008, d, 4'hf, 0, r); // bank 2, index 0
		apply_write(32'h008, d, 4'hf);
		lsu_read(32'h1008, 0, d, r); // bank 2, index 256
		check_val("oor read resp", 32'(SLVERR), {30'd0, r});
		check_val("oor read data", 32'd0, d);
		lsu_write(32'h1008, 32'hdeadbeef, 4'hf, 0, r);
		check_val("oor write resp", 32'(SLVERR), {30'd0, r});
		lsu_read(32'h008, 0, d, r);
		check_val("aliased word kept", model[32'h008 >> 2], d);
		end_test();
	endtask

	task automatic back_pressure();
		logic [31:0] wd, di, dl;
		logic [1:0]  rw, ri, rl;
		int          hw, hi, hl;
		begin_test("back_pressure");
		for (int k = 0; k < 4; k++) begin
			wd = $random(seed);
			hw = $random(seed) & 7;
			hi = $random(seed) & 7;
			hl = $random(seed) & 7;
			fork
				lsu_write(32'h800 + 32'(k * 4), wd, 4'hf, hw, rw);
				ifu_read(wr_addr[k], hi, di, ri);
				lsu_read(wr_addr[k+8], hl, dl, rl);
			join
			apply_write(32'h800 + 32'(k * 4), wd, 4'hf);
			check_val("ifu data", model[wr_addr[k][11:2]], di);
			check_val("lsu data", model[wr_addr[k+8][11:2]], dl);
			check_val("resp codes", 32'(OKAY), {30'd0, rw | ri | rl});
		end
		for (int k = 0; k < 4; k++) begin
			hl = $random(seed) & 7;
			lsu_read(32'h800 + 32'(k * 4), hl, dl, rl);
			check_val("stalled write data", model[(32'h800 >> 2) + k], dl);
		end
		end_test();
	endtask

	initial begin
		arst_n      = 1'b0;
		ifu_araddr  = '0;
		ifu_arvalid = 1'b0;
		ifu_rready  = 1'b0;
		lsu_araddr  = '0;
		lsu_arvalid = 1'b0;
		lsu_rready  = 1'b0;
		lsu_awaddr  = '0;
		lsu_awvalid = 1'b0;
		lsu_wdata   = '0;
		lsu_wstrb   = '0;
		lsu_wvalid  = 1'b0;
		lsu_bready  = 1'b0;
		repeat (10) @(posedge clk);
		#1 arst_n = 1'b1;
		reset_state();
		write_read_back();
		byte_strobes();
		concurrent_reads();
		out_of_range();
		back_pressure();
		$display("Summary: %0d tests ok, %0d with errors, %0d mismatches, %0d assertion failures",
			tests_ok, tests_bad, errors, dut_i.u_props.viol_count);
		if (errors == 0 && tests_bad == 0 && dut_i.u_props.viol_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule
